//--- dir_cfg_pkg.sv
// --------------------------------------------------
// directory geometry: set, way and tag widths
// --------------------------------------------------
package dir_cfg_pkg;

  localparam int WAY_BITS  = 2;
  localparam int NUM_WAY   = 1 << WAY_BITS;
  localparam int SET_BITS  = 3;
  localparam int NUM_SET   = 1 << SET_BITS;
  localparam int TAG_BITS  = 8;
  localparam int NUM_ENTRY = NUM_SET * NUM_WAY;  // entries visited by a flush walk

  typedef logic [WAY_BITS-1:0] way_t;
  typedef logic [SET_BITS-1:0] set_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  // one bit per way of a set
  typedef logic [NUM_WAY-1:0] way_vec_t;

  // set in the upper bits, way in the lower
  typedef logic [SET_BITS+WAY_BITS-1:0] entry_idx_t;

  typedef logic [NUM_WAY-1:0][TAG_BITS-1:0] way_tags_t;  // all tags of one set

endpackage

//--- dir_tl_pkg.sv
// --------------------------------------------------
// request fields: opcodes and source ids
// --------------------------------------------------
package dir_tl_pkg;

  localparam int OP_BITS     = 3;
  localparam int SOURCE_BITS = 4;

  typedef logic [OP_BITS-1:0]     opcode_t;
  typedef logic [SOURCE_BITS-1:0] source_t;

  localparam opcode_t OP_PUT_FULL    = 3'd0;
  localparam opcode_t OP_PUT_PARTIAL = 3'd1;
  localparam opcode_t OP_GET         = 3'd4;
  localparam opcode_t OP_HINT        = 3'd5;  // reported on flush steps

endpackage

//--- tag_sram.sv
// --------------------------------------------------
// tag store, one read port and a way-masked write
// port, cleared set by set after reset
// --------------------------------------------------
`timescale 1ns/1ps

module tag_sram (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rd_en_i,
  input  dir_cfg_pkg::set_t      rd_set_i,
  output dir_cfg_pkg::way_tags_t rd_tags_o,
  input  logic                   wr_en_i,
  input  dir_cfg_pkg::set_t      wr_set_i,
  input  dir_cfg_pkg::way_t      wr_way_i,
  input  dir_cfg_pkg::tag_t      wr_tag_i,
  output logic                   wipe_done_o
);
  import dir_cfg_pkg::*;

  way_tags_t         mem [NUM_SET];
  logic [SET_BITS:0] wipe_cnt;  // msb rises once every set is cleared

  assign wipe_done_o = wipe_cnt[SET_BITS];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wipe_cnt <= '0;
    else if (!wipe_done_o)
      wipe_cnt <= wipe_cnt + 1'b1;
  end

  // wipe owns the write port until it is done
  always_ff @(posedge clk)
  begin
    if (!wipe_done_o)
      mem[wipe_cnt[SET_BITS-1:0]] <= '0;
    else if (wr_en_i)
      mem[wr_set_i][wr_way_i] <= wr_tag_i;  // only the addressed way
    if (rd_en_i)
      rd_tags_o <= mem[rd_set_i];
  end

endmodule

//--- lru_matrix.sv
// --------------------------------------------------
// per-set age matrices, gives the LRU way of a set
// --------------------------------------------------
`timescale 1ns/1ps

module lru_matrix (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              touch_en_i,
  input  dir_cfg_pkg::set_t touch_set_i,
  input  dir_cfg_pkg::way_t touch_way_i,
  input  logic              wr_touch_en_i,
  input  dir_cfg_pkg::set_t wr_touch_set_i,
  input  dir_cfg_pkg::way_t wr_touch_way_i,
  input  dir_cfg_pkg::set_t query_set_i,
  output dir_cfg_pkg::way_t lru_way_o
);
  import dir_cfg_pkg::*;

  // age[i][j] high when way i was used before way j
  typedef logic [NUM_WAY-1:0][NUM_WAY-1:0] age_t;

  age_t older [NUM_SET];

  function automatic age_t touch(input age_t age, input way_t way);
    age_t nxt;
    nxt = age;
    for (int i = 0; i < NUM_WAY; i++)
    begin
      nxt[way][i] = 1'b0;                 // now younger than everyone
      nxt[i][way] = (i != int'(way));
    end
    return nxt;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int s = 0; s < NUM_SET; s++)
        for (int i = 0; i < NUM_WAY; i++)
          for (int j = 0; j < NUM_WAY; j++)
            older[s][i][j] <= (i < j);  // way 0 oldest
    end
    else
    begin
      if (touch_en_i)
        older[touch_set_i] <= touch(older[touch_set_i], touch_way_i);
      if (wr_touch_en_i)
        older[wr_touch_set_i] <= touch(older[wr_touch_set_i], wr_touch_way_i);
    end
  end

  // the way older than all others
  always_comb
  begin
    lru_way_o = '0;
    for (int i = 0; i < NUM_WAY; i++)
      if (&(older[query_set_i][i] | (way_vec_t'(1) << i)))
        lru_way_o = way_t'(i);
  end

endmodule

//--- dir_status.sv
// --------------------------------------------------
// valid and dirty bits of every directory entry
// --------------------------------------------------
`timescale 1ns/1ps

module dir_status (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en_i,
  input  dir_cfg_pkg::set_t     wr_set_i,
  input  dir_cfg_pkg::way_t     wr_way_i,
  input  logic                  upd_en_i,
  input  dir_cfg_pkg::set_t     upd_set_i,
  input  dir_cfg_pkg::way_t     upd_way_i,
  input  logic                  upd_flush_i,
  input  logic                  upd_invalidate_i,
  input  logic                  upd_hit_i,
  input  logic                  upd_put_i,
  input  dir_cfg_pkg::set_t     rd_set_i,
  output dir_cfg_pkg::way_vec_t valid_o,
  output dir_cfg_pkg::way_vec_t dirty_o
);
  import dir_cfg_pkg::*;

  way_vec_t valid_q [NUM_SET];
  way_vec_t dirty_q [NUM_SET];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int s = 0; s < NUM_SET; s++)
      begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
    end
    else if (wr_en_i)
    begin
      valid_q[wr_set_i][wr_way_i] <= 1'b1;  // fresh install is clean
      dirty_q[wr_set_i][wr_way_i] <= 1'b0;
    end
    else if (upd_en_i)
    begin
      if (upd_flush_i)
      begin
        dirty_q[upd_set_i][upd_way_i] <= 1'b0;
        if (upd_invalidate_i)
          valid_q[upd_set_i][upd_way_i] <= 1'b0;
      end
      else if (upd_hit_i)
      begin
        if (upd_put_i)
          dirty_q[upd_set_i][upd_way_i] <= 1'b1;
      end
      else
      begin
        // victim reserved for the refill
        valid_q[upd_set_i][upd_way_i] <= 1'b0;
        dirty_q[upd_set_i][upd_way_i] <= 1'b0;
      end
    end
  end

  assign valid_o = valid_q[rd_set_i];
  assign dirty_o = dirty_q[rd_set_i];

endmodule

//--- flush_walker.sv
// --------------------------------------------------
// flush/invalidate walk over all entries
// --------------------------------------------------
`timescale 1ns/1ps

module flush_walker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic                    invalidate_i,
  input  logic                    start_ok_i,
  input  logic                    step_done_i,
  output logic                    active_o,
  output logic                    invalidate_o,
  output dir_cfg_pkg::entry_idx_t entry_o,
  output logic                    last_o
);
  import dir_cfg_pkg::*;

  logic       active_q;
  logic       inv_q;
  entry_idx_t cnt_q;  // set-then-way order

  assign last_o = (cnt_q == entry_idx_t'(NUM_ENTRY - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active_q <= 1'b0;
      inv_q    <= 1'b0;
      cnt_q    <= '0;
    end
    else if (start_ok_i && (flush_i || invalidate_i))
    begin
      active_q <= 1'b1;
      inv_q    <= invalidate_i;
      cnt_q    <= '0;
    end
    else if (step_done_i)
    begin
      cnt_q <= cnt_q + 1'b1;  // wraps back to zero after the last entry
      if (last_o)
        active_q <= 1'b0;
    end
  end

  assign active_o     = active_q;
  assign invalidate_o = inv_q;
  assign entry_o      = cnt_q;

endmodule

//--- dir_pipeline.sv
// --------------------------------------------------
// lookup pipeline: issue, tag compare, result
// register and status updates at the handshake
// --------------------------------------------------
`timescale 1ns/1ps

module dir_pipeline (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wipe_done_i,
  input  logic                    read_valid_i,
  output logic                    read_ready_o,
  input  dir_cfg_pkg::set_t       read_set_i,
  input  dir_cfg_pkg::tag_t       read_tag_i,
  input  dir_tl_pkg::opcode_t     read_opcode_i,
  input  dir_tl_pkg::source_t     read_source_i,
  output logic                    result_valid_o,
  input  logic                    result_ready_i,
  output logic                    result_hit_o,
  output dir_cfg_pkg::way_t       result_way_o,
  output dir_cfg_pkg::tag_t       result_victim_tag_o,
  output logic                    result_dirty_o,
  output dir_cfg_pkg::set_t       result_set_o,
  output dir_cfg_pkg::tag_t       result_tag_o,
  output dir_tl_pkg::opcode_t     result_opcode_o,
  output dir_tl_pkg::source_t     result_source_o,
  output logic                    result_flush_o,
  output logic                    result_last_flush_o,
  input  logic                    write_valid_i,
  output logic                    ready_o,
  input  logic                    walk_active_i,
  input  logic                    walk_invalidate_i,
  input  dir_cfg_pkg::entry_idx_t walk_entry_i,
  input  logic                    walk_last_i,
  output logic                    step_done_o,
  output logic                    sram_rd_en_o,
  output dir_cfg_pkg::set_t       sram_rd_set_o,
  input  dir_cfg_pkg::way_tags_t  sram_tags_i,
  input  dir_cfg_pkg::way_vec_t   valid_i,
  input  dir_cfg_pkg::way_vec_t   dirty_i,
  output dir_cfg_pkg::set_t       lru_query_set_o,
  input  dir_cfg_pkg::way_t       lru_way_i,
  output logic                    upd_en_o,
  output dir_cfg_pkg::set_t       upd_set_o,
  output dir_cfg_pkg::way_t       upd_way_o,
  output logic                    upd_flush_o,
  output logic                    upd_invalidate_o,
  output logic                    upd_hit_o,
  output logic                    upd_put_o,
  output logic                    touch_en_o
);
  import dir_cfg_pkg::*;
  import dir_tl_pkg::*;

  logic     s1_valid;  // request captured, tags being read
  logic     s2_valid;  // tags back, compare cycle
  logic     s1_flush;
  logic     s1_inv;
  logic     s1_last;
  set_t     s1_set;
  way_t     s1_way;
  tag_t     s1_tag;
  opcode_t  s1_opcode;
  source_t  s1_source;
  logic     res_inv;
  logic     busy;
  logic     read_fire;
  logic     step_issue;
  logic     res_fire;
  way_vec_t hits;
  way_t     hit_way;
  way_t     sel_way;

  assign busy         = s1_valid | s2_valid | result_valid_o;  // one op in flight
  assign ready_o      = wipe_done_i & ~walk_active_i & ~busy;
  assign read_ready_o = ready_o & ~write_valid_i;  // writes go first
  assign read_fire    = read_valid_i & read_ready_o;
  assign step_issue   = walk_active_i & ~busy;
  assign res_fire     = result_valid_o & result_ready_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end
    else
    begin
      s1_valid <= read_fire | step_issue;
      s2_valid <= s1_valid;
    end
  end

  // address select: walk entry or read request
  always_ff @(posedge clk)
  begin
    if (step_issue)
    begin
      s1_flush            <= 1'b1;
      s1_inv              <= walk_invalidate_i;
      s1_last             <= walk_last_i;
      {s1_set, s1_way}    <= walk_entry_i;
      s1_opcode           <= OP_HINT;
      s1_source           <= '0;
    end
    else if (read_fire)
    begin
      s1_flush  <= 1'b0;
      s1_inv    <= 1'b0;
      s1_last   <= 1'b0;
      s1_set    <= read_set_i;
      s1_tag    <= read_tag_i;
      s1_opcode <= read_opcode_i;
      s1_source <= read_source_i;
    end
  end

  assign sram_rd_en_o    = s1_valid;
  assign sram_rd_set_o   = s1_set;
  assign lru_query_set_o = s1_set;

  // lowest matching way wins
  always_comb
  begin
    hit_way = '0;
    for (int w = NUM_WAY - 1; w >= 0; w--)
    begin
      hits[w] = valid_i[w] && (sram_tags_i[w] == s1_tag);
      if (hits[w])
        hit_way = way_t'(w);
    end
  end

  assign sel_way = s1_flush ? s1_way : (|hits ? hit_way : lru_way_i);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      result_valid_o <= 1'b0;
    else if (s2_valid)
      result_valid_o <= 1'b1;
    else if (res_fire)
      result_valid_o <= 1'b0;
  end

  // held until consumed, nothing new issues meanwhile
  always_ff @(posedge clk)
  begin
    if (s2_valid)
    begin
      result_hit_o        <= s1_flush | (|hits);
      result_way_o        <= sel_way;
      result_victim_tag_o <= sram_tags_i[sel_way];
      result_dirty_o      <= dirty_i[sel_way];
      result_set_o        <= s1_set;
      result_tag_o        <= s1_flush ? sram_tags_i[sel_way] : s1_tag;
      result_opcode_o     <= s1_opcode;
      result_source_o     <= s1_source;
      result_flush_o      <= s1_flush;
      result_last_flush_o <= s1_last;
      res_inv             <= s1_inv;
    end
  end

  assign upd_en_o         = res_fire;
  assign upd_set_o        = result_set_o;
  assign upd_way_o        = result_way_o;
  assign upd_flush_o      = result_flush_o;
  assign upd_invalidate_o = res_inv;
  assign upd_hit_o        = result_hit_o;
  assign upd_put_o        = (result_opcode_o == OP_PUT_FULL) ||
                            (result_opcode_o == OP_PUT_PARTIAL);
  assign touch_en_o       = res_fire & ~result_flush_o;  // flush leaves LRU alone
  assign step_done_o      = res_fire & result_flush_o;

endmodule

//--- l2_directory.sv
// --------------------------------------------------
// L2 slice tag directory top level
// --------------------------------------------------
`timescale 1ns/1ps

module l2_directory (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                write_valid_i,
  output logic                write_ready_o,
  input  dir_cfg_pkg::set_t   write_set_i,
  input  dir_cfg_pkg::way_t   write_way_i,
  input  dir_cfg_pkg::tag_t   write_tag_i,
  input  logic                read_valid_i,
  output logic                read_ready_o,
  input  dir_cfg_pkg::set_t   read_set_i,
  input  dir_cfg_pkg::tag_t   read_tag_i,
  input  dir_tl_pkg::opcode_t read_opcode_i,
  input  dir_tl_pkg::source_t read_source_i,
  output logic                result_valid_o,
  input  logic                result_ready_i,
  output logic                result_hit_o,
  output dir_cfg_pkg::way_t   result_way_o,
  output dir_cfg_pkg::tag_t   result_victim_tag_o,
  output logic                result_dirty_o,
  output dir_cfg_pkg::set_t   result_set_o,
  output dir_cfg_pkg::tag_t   result_tag_o,
  output dir_tl_pkg::opcode_t result_opcode_o,
  output dir_tl_pkg::source_t result_source_o,
  output logic                result_flush_o,
  output logic                result_last_flush_o,
  output logic                ready_o,
  input  logic                flush_i,
  input  logic                invalidate_i
);
  import dir_cfg_pkg::*;

  logic       write_fire;
  logic       wipe_done;
  logic       sram_rd_en;
  set_t       sram_rd_set;
  way_tags_t  sram_tags;
  way_vec_t   valid;
  way_vec_t   dirty;
  set_t       lru_query_set;
  way_t       lru_way;
  logic       upd_en;
  set_t       upd_set;
  way_t       upd_way;
  logic       upd_flush;
  logic       upd_invalidate;
  logic       upd_hit;
  logic       upd_put;
  logic       touch_en;
  logic       walk_active;
  logic       walk_invalidate;
  entry_idx_t walk_entry;
  logic       walk_last;
  logic       step_done;

  assign write_ready_o = ready_o;
  assign write_fire    = write_valid_i & ready_o;

  tag_sram tag_sram_i (
    .clk,
    .rst_n,
    .rd_en_i     (sram_rd_en),
    .rd_set_i    (sram_rd_set),
    .rd_tags_o   (sram_tags),
    .wr_en_i     (write_fire),
    .wr_set_i    (write_set_i),
    .wr_way_i    (write_way_i),
    .wr_tag_i    (write_tag_i),
    .wipe_done_o (wipe_done)
  );

  lru_matrix lru_matrix_i (
    .clk,
    .rst_n,
    .touch_en_i     (touch_en),
    .touch_set_i    (upd_set),
    .touch_way_i    (upd_way),
    .wr_touch_en_i  (write_fire),  // an install counts as a use
    .wr_touch_set_i (write_set_i),
    .wr_touch_way_i (write_way_i),
    .query_set_i    (lru_query_set),
    .lru_way_o      (lru_way)
  );

  dir_status dir_status_i (
    .clk,
    .rst_n,
    .wr_en_i          (write_fire),
    .wr_set_i         (write_set_i),
    .wr_way_i         (write_way_i),
    .upd_en_i         (upd_en),
    .upd_set_i        (upd_set),
    .upd_way_i        (upd_way),
    .upd_flush_i      (upd_flush),
    .upd_invalidate_i (upd_invalidate),
    .upd_hit_i        (upd_hit),
    .upd_put_i        (upd_put),
    .rd_set_i         (sram_rd_set),  // same set as the tag read
    .valid_o          (valid),
    .dirty_o          (dirty)
  );

  flush_walker flush_walker_i (
    .clk,
    .rst_n,
    .flush_i,
    .invalidate_i,
    .start_ok_i   (ready_o),
    .step_done_i  (step_done),
    .active_o     (walk_active),
    .invalidate_o (walk_invalidate),
    .entry_o      (walk_entry),
    .last_o       (walk_last)
  );

  dir_pipeline dir_pipeline_i (
    .clk,
    .rst_n,
    .wipe_done_i         (wipe_done),
    .read_valid_i,
    .read_ready_o,
    .read_set_i,
    .read_tag_i,
    .read_opcode_i,
    .read_source_i,
    .result_valid_o,
    .result_ready_i,
    .result_hit_o,
    .result_way_o,
    .result_victim_tag_o,
    .result_dirty_o,
    .result_set_o,
    .result_tag_o,
    .result_opcode_o,
    .result_source_o,
    .result_flush_o,
    .result_last_flush_o,
    .write_valid_i,
    .ready_o,
    .walk_active_i       (walk_active),
    .walk_invalidate_i   (walk_invalidate),
    .walk_entry_i        (walk_entry),
    .walk_last_i         (walk_last),
    .step_done_o         (step_done),
    .sram_rd_en_o        (sram_rd_en),
    .sram_rd_set_o       (sram_rd_set),
    .sram_tags_i         (sram_tags),
    .valid_i             (valid),
    .dirty_i             (dirty),
    .lru_query_set_o     (lru_query_set),
    .lru_way_i           (lru_way),
    .upd_en_o            (upd_en),
    .upd_set_o           (upd_set),
    .upd_way_o           (upd_way),
    .upd_flush_o         (upd_flush),
    .upd_invalidate_o    (upd_invalidate),
    .upd_hit_o           (upd_hit),
    .upd_put_o           (upd_put),
    .touch_en_o          (touch_en)
  );

endmodule

//--- tb_dir_tasks.svh
// --------------------------------------------------
// drive tasks, typed compares and directed tests
// for the L2 directory testbench
// --------------------------------------------------

// expected result fields
logic    exp_hit;
way_t    exp_way;
tag_t    exp_victim_tag;
logic    exp_dirty;
set_t    exp_set;
tag_t    exp_tag;
opcode_t exp_opcode;
source_t exp_source;
logic    exp_flush;
logic    exp_last;

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  end
endtask

task automatic check_way(input string name, input way_t got, input way_t exp);
  if (got !== exp)
  begin
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  end
endtask

task automatic check_tag(input string name, input tag_t got, input tag_t exp);
  if (got !== exp)
  begin
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  end
endtask

task automatic check_set(input string name, input set_t got, input set_t exp);
  if (got !== exp)
  begin
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  end
endtask

task automatic check_opcode(input string name, input opcode_t got, input opcode_t exp);
  if (got !== exp)
  begin
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  end
endtask

task automatic check_source(input string name, input source_t got, input source_t exp);
  if (got !== exp)
  begin
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    stop_run();
  end
endtask

task automatic check_result();
  check_bit("result_valid_o", result_valid_o, 1'b1);
  check_bit("result_hit_o", result_hit_o, exp_hit);
  check_way("result_way_o", result_way_o, exp_way);
  check_tag("result_victim_tag_o", result_victim_tag_o, exp_victim_tag);
  check_bit("result_dirty_o", result_dirty_o, exp_dirty);
  check_set("result_set_o", result_set_o, exp_set);
  check_tag("result_tag_o", result_tag_o, exp_tag);
  check_opcode("result_opcode_o", result_opcode_o, exp_opcode);
  check_source("result_source_o", result_source_o, exp_source);
  check_bit("result_flush_o", result_flush_o, exp_flush);
  check_bit("result_last_flush_o", result_last_flush_o, exp_last);
endtask

// called at a falling edge with the result showing
task automatic consume_result(input int gap);
  repeat (gap)
  begin
    @(negedge clk);
    check_result();  // must hold while stalled
    check_bit("read_ready_o", read_ready_o, 1'b0);
  end
  result_ready_i = 1'b1;
  @(negedge clk);
  result_ready_i = 1'b0;
  check_bit("result_valid_o", result_valid_o, 1'b0);  // taken exactly once
endtask

// unique per set and way, random upper bits
function automatic tag_t make_tag(input set_t s, input way_t w);
  logic [2:0] salt;
  salt = 3'($urandom_range(7, 0));
  return {salt, s, w};
endfunction

task automatic write_entry(input set_t s, input way_t w, input tag_t t);
  @(negedge clk);
  write_valid_i = 1'b1;
  write_set_i   = s;
  write_way_i   = w;
  write_tag_i   = t;
  while (!write_ready_o)
    @(negedge clk);
  @(negedge clk);
  write_valid_i = 1'b0;
  m_tag[s][w]   = t;
  m_valid[s][w] = 1'b1;
  m_dirty[s][w] = 1'b0;
  touch_lru(s, w);
endtask

task automatic lookup(input set_t s, input tag_t t, input opcode_t op, input source_t src,
                      input int gap, output logic hit, output way_t way, output logic dirty);
  int   lat;
  logic p_hit;
  way_t p_way;
  @(negedge clk);
  read_valid_i  = 1'b1;
  read_set_i    = s;
  read_tag_i    = t;
  read_opcode_i = op;
  read_source_i = src;
  while (!read_ready_o)
    @(negedge clk);
  @(negedge clk);  // accepted at the edge just passed
  read_valid_i = 1'b0;
  lat = 0;
  while (!result_valid_o)
  begin
    @(negedge clk);
    lat++;
  end
  if (lat != 2)
  begin
    $display("lookup result came %0d edges after acceptance instead of 2", lat);
    stop_run();
  end
  predict_lookup(s, t, p_hit, p_way);
  exp_hit        = p_hit;
  exp_way        = p_way;
  exp_victim_tag = m_tag[s][p_way];
  exp_dirty      = m_dirty[s][p_way];
  exp_set        = s;
  exp_tag        = t;
  exp_opcode     = op;
  exp_source     = src;
  exp_flush      = 1'b0;
  exp_last       = 1'b0;
  check_result();
  hit   = result_hit_o;
  way   = result_way_o;
  dirty = result_dirty_o;
  consume_result(gap);
  if (p_hit && (op == OP_PUT_FULL || op == OP_PUT_PARTIAL))
    m_dirty[s][p_way] = 1'b1;
  else if (!p_hit)
  begin
    m_valid[s][p_way] = 1'b0;  // reserved for refill
    m_dirty[s][p_way] = 1'b0;
  end
  touch_lru(s, p_way);
endtask

task automatic run_walk(input logic inv);
  set_t s;
  way_t w;
  @(negedge clk);
  while (!ready_o)
    @(negedge clk);
  flush_i      = ~inv;
  invalidate_i = inv;
  @(negedge clk);
  flush_i      = 1'b0;
  invalidate_i = 1'b0;
  for (int e = 0; e < NUM_ENTRY; e++)
  begin
    s = set_t'(e / NUM_WAY);
    w = way_t'(e % NUM_WAY);
    while (!result_valid_o)
      @(negedge clk);
    exp_hit        = 1'b1;
    exp_way        = w;
    exp_victim_tag = m_tag[s][w];
    exp_dirty      = m_dirty[s][w];
    exp_set        = s;
    exp_tag        = m_tag[s][w];
    exp_opcode     = OP_HINT;
    exp_source     = '0;
    exp_flush      = 1'b1;
    exp_last       = (e == NUM_ENTRY - 1);
    check_result();
    consume_result($urandom_range(3, 0));
    m_dirty[s][w] = 1'b0;
    if (inv)
      m_valid[s][w] = 1'b0;
  end
  check_bit("ready_o", ready_o, 1'b1);  // walk over
endtask

task automatic test_reset_misses();
  int   low_cycles;
  logic hit;
  logic dirty;
  way_t way;
  check_bit("result_valid_o", result_valid_o, 1'b0);
  check_bit("ready_o", ready_o, 1'b0);
  check_bit("write_ready_o", write_ready_o, 1'b0);
  check_bit("read_ready_o", read_ready_o, 1'b0);
  low_cycles = 0;
  while (!ready_o)
  begin
    low_cycles++;
    @(negedge clk);
  end
  if (low_cycles != NUM_SET)
  begin
    $display("ready_o rose after %0d wipe cycles instead of %0d", low_cycles, NUM_SET);
    stop_run();
  end
  // victims rotate through the ways
  for (int i = 0; i < NUM_WAY; i++)
  begin
    lookup(3'd2, tag_t'($urandom), OP_GET, source_t'(i), $urandom_range(2, 0),
           hit, way, dirty);
    check_bit("result_hit_o", hit, 1'b0);
    check_way("result_way_o", way, way_t'(i));
    check_bit("result_dirty_o", dirty, 1'b0);
  end
endtask

task automatic test_write_get();
  set_t s;
  way_t w;
  logic hit;
  logic dirty;
  way_t way;
  for (int si = 0; si < NUM_SET; si++)
    for (int wi = 0; wi < NUM_WAY; wi++)
      write_entry(set_t'(si), way_t'(wi), make_tag(set_t'(si), way_t'(wi)));
  for (int i = 0; i < 8; i++)
  begin
    s = set_t'($urandom_range(NUM_SET - 1, 0));
    w = way_t'($urandom_range(NUM_WAY - 1, 0));
    lookup(s, m_tag[s][w], OP_GET, source_t'($urandom), $urandom_range(3, 0),
           hit, way, dirty);
    check_bit("result_hit_o", hit, 1'b1);
    check_way("result_way_o", way, w);
    check_bit("result_dirty_o", dirty, 1'b0);
  end
endtask

task automatic test_put_and_miss();
  logic hit;
  logic dirty;
  way_t way;
  way_t victim;
  tag_t old_tag;
  lookup(3'd1, m_tag[1][2], OP_PUT_FULL, 4'd3, 1, hit, way, dirty);
  check_bit("result_hit_o", hit, 1'b1);
  lookup(3'd1, m_tag[1][2], OP_GET, 4'd4, 0, hit, way, dirty);
  check_way("result_way_o", way, 2'd2);
  check_bit("result_dirty_o", dirty, 1'b1);
  lookup(3'd5, m_tag[5][0], OP_PUT_PARTIAL, 4'd9, 2, hit, way, dirty);
  check_bit("result_hit_o", hit, 1'b1);
  victim  = m_order[1][0];
  old_tag = m_tag[1][victim];
  // a set field of 2 never matches in set 1
  lookup(3'd1, make_tag(3'd2, 2'd0), OP_GET, 4'd5, 1, hit, way, dirty);
  check_bit("result_hit_o", hit, 1'b0);
  check_way("result_way_o", way, victim);
  lookup(3'd1, old_tag, OP_GET, 4'd6, 0, hit, way, dirty);
  check_bit("result_hit_o", hit, 1'b0);
endtask

task automatic test_back_pressure();
  set_t s;
  way_t w;
  logic hit;
  logic dirty;
  way_t way;
  for (int i = 0; i < 6; i++)
  begin
    s = set_t'($urandom_range(NUM_SET - 1, 0));
    w = way_t'($urandom_range(NUM_WAY - 1, 0));
    lookup(s, m_tag[s][w], OP_GET, source_t'($urandom), $urandom_range(6, 2),
           hit, way, dirty);
  end
endtask

task automatic test_flush();
  logic hit;
  logic dirty;
  way_t way;
  run_walk(1'b0);
  for (int s = 0; s < NUM_SET; s++)
    for (int w = 0; w < NUM_WAY; w++)
      if (m_valid[s][w])
      begin
        lookup(set_t'(s), m_tag[s][w], OP_GET, source_t'(w), 0, hit, way, dirty);
        check_bit("result_hit_o", hit, 1'b1);
        check_way("result_way_o", way, way_t'(w));
        check_bit("result_dirty_o", dirty, 1'b0);
      end
endtask

task automatic test_invalidate();
  logic hit;
  logic dirty;
  way_t way;
  run_walk(1'b1);
  for (int s = 0; s < NUM_SET; s++)
    for (int w = 0; w < NUM_WAY; w++)
    begin
      lookup(set_t'(s), m_tag[s][w], OP_GET, source_t'(s), 0, hit, way, dirty);
      check_bit("result_hit_o", hit, 1'b0);
    end
endtask

//--- tb_l2_directory.sv
// --------------------------------------------------
// testbench for the L2 tag directory, with a model
// of tags, valid and dirty bits and LRU order
// --------------------------------------------------
`timescale 1ns/1ps

module tb_l2_directory;
  import dir_cfg_pkg::*;
  import dir_tl_pkg::*;

  // about 90 lookups of up to 11 cycles, 64 walk steps of up to 7,
  // 32 writes of 2 and the wipe come to roughly 1500 cycles
  localparam int MAX_CYCLES = 2000;

  logic    clk;
  logic    rst_n;
  logic    write_valid_i;
  logic    write_ready_o;
  set_t    write_set_i;
  way_t    write_way_i;
  tag_t    write_tag_i;
  logic    read_valid_i;
  logic    read_ready_o;
  set_t    read_set_i;
  tag_t    read_tag_i;
  opcode_t read_opcode_i;
  source_t read_source_i;
  logic    result_valid_o;
  logic    result_ready_i;
  logic    result_hit_o;
  way_t    result_way_o;
  tag_t    result_victim_tag_o;
  logic    result_dirty_o;
  set_t    result_set_o;
  tag_t    result_tag_o;
  opcode_t result_opcode_o;
  source_t result_source_o;
  logic    result_flush_o;
  logic    result_last_flush_o;
  logic    ready_o;
  logic    flush_i;
  logic    invalidate_i;
  int      cycle_cnt = 0;

  // reference model
  tag_t m_tag   [NUM_SET][NUM_WAY];
  logic m_valid [NUM_SET][NUM_WAY];
  logic m_dirty [NUM_SET][NUM_WAY];
  way_t m_order [NUM_SET][NUM_WAY];  // oldest way first

  l2_directory l2_directory_i (
    .clk, .rst_n,
    .write_valid_i, .write_ready_o, .write_set_i, .write_way_i, .write_tag_i,
    .read_valid_i, .read_ready_o, .read_set_i, .read_tag_i,
    .read_opcode_i, .read_source_i,
    .result_valid_o, .result_ready_i, .result_hit_o, .result_way_o,
    .result_victim_tag_o, .result_dirty_o, .result_set_o, .result_tag_o,
    .result_opcode_o, .result_source_o, .result_flush_o, .result_last_flush_o,
    .ready_o, .flush_i, .invalidate_i
  );

  initial
    clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      stop_run();
    end
  end

  task automatic reset_model();
    for (int s = 0; s < NUM_SET; s++)
      for (int w = 0; w < NUM_WAY; w++)
      begin
        m_tag[s][w]   = '0;  // wiped after reset
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_order[s][w] = way_t'(w);
      end
  endtask

  // move a way to the newest position of its set
  task automatic touch_lru(input set_t s, input way_t w);
    int pos;
    pos = 0;
    for (int i = 0; i < NUM_WAY; i++)
      if (m_order[s][i] == w)
        pos = i;
    for (int i = pos; i < NUM_WAY - 1; i++)
      m_order[s][i] = m_order[s][i+1];
    m_order[s][NUM_WAY-1] = w;
  endtask

  // lowest valid matching way, else the oldest way
  task automatic predict_lookup(input set_t s, input tag_t t, output logic hit,
                                output way_t way);
    hit = 1'b0;
    way = m_order[s][0];
    for (int i = NUM_WAY - 1; i >= 0; i--)
      if (m_valid[s][i] && (m_tag[s][i] == t))
      begin
        hit = 1'b1;
        way = way_t'(i);
      end
  endtask

  `include "tb_dir_tasks.svh"

  initial
  begin
    void'($urandom(56));
    rst_n          = 1'b0;
    write_valid_i  = 1'b0;
    write_set_i    = '0;
    write_way_i    = '0;
    write_tag_i    = '0;
    read_valid_i   = 1'b0;
    read_set_i     = '0;
    read_tag_i     = '0;
    read_opcode_i  = OP_GET;
    read_source_i  = '0;
    result_ready_i = 1'b0;
    flush_i        = 1'b0;
    invalidate_i   = 1'b0;
    reset_model();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_misses();
    test_write_get();
    test_put_and_miss();
    test_back_pressure();
    test_flush();
    test_invalidate();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+.
dir_cfg_pkg.sv
dir_tl_pkg.sv
tag_sram.sv
lru_matrix.sv
dir_status.sv
flush_walker.sv
dir_pipeline.sv
l2_directory.sv
tb_l2_directory.sv

//--- Bender.yml
package:
  name: l2_directory

sources:
  - dir_cfg_pkg.sv
  - dir_tl_pkg.sv
  - tag_sram.sv
  - lru_matrix.sv
  - dir_status.sv
  - flush_walker.sv
  - dir_pipeline.sv
  - l2_directory.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_l2_directory.sv
